// ==== hw/fixedPointPkg.sv ====
package fixedPointPkg;

	// Signed Q8.8 format.
	localparam int ActBits = 16;
	localparam int FracBits = 8;

	// Wide enough for a full row of shifted products plus bias.
	localparam int AccBits = 24;

	// One activation, weight or bias.
	typedef logic signed [ActBits-1:0] act_t;

	// Sum of shifted products.
	typedef logic signed [AccBits-1:0] acc_t;

	// Full-width product of two Q8.8 values, Q16.16.
	typedef logic signed [2*ActBits-1:0] prod_t;

	// Saturation limits of act_t.
	localparam act_t ActMax = {1'b0, {(ActBits-1){1'b1}}};
	localparam act_t ActMin = {1'b1, {(ActBits-1){1'b0}}};

endpackage

// ==== hw/mlpNetPkg.sv ====
package mlpNetPkg;

	import fixedPointPkg::*;

	// Network shape.
	localparam int NumFeatures = 15;
	localparam int NumHidden = 4;
	localparam int NumClasses = 3;
	localparam int ClassIdxBits = $clog2(NumClasses);

	// Trained hidden layer, one row per neuron, Q8.8.
	localparam act_t [0:NumHidden-1][0:NumFeatures-1] HiddenWeights = '{
		'{
			16'sh00B9, 16'shFD8B, 16'shFFA1, 16'sh0012, 16'sh0143,
			16'sh00DE, 16'shFFD4, 16'sh028C, 16'shFE6A, 16'sh0116,
			16'shFEF7, 16'shFDD4, 16'sh0186, 16'shFEC1, 16'sh017C
		},
		'{
			16'shFF3A, 16'sh0098, 16'sh01C2, 16'shFE11, 16'sh0034,
			16'shFFB0, 16'sh0210, 16'shFF05, 16'sh0077, 16'shFE9C,
			16'sh00C4, 16'sh0153, 16'shFF62, 16'sh002E, 16'shFDF0
		},
		'{
			16'sh0231, 16'shFF7D, 16'sh0009, 16'sh00E6, 16'shFE48,
			16'sh0185, 16'shFF2B, 16'shFFEE, 16'sh01A0, 16'sh0062,
			16'shFD9E, 16'sh0047, 16'sh011B, 16'shFF88, 16'sh00F3
		},
		'{
			16'shFE75, 16'sh0128, 16'shFFC9, 16'sh0301, 16'sh0055,
			16'shFE0A, 16'sh00B2, 16'sh0167, 16'shFF19, 16'shFFD7,
			16'sh0240, 16'shFE83, 16'sh0029, 16'sh00DA, 16'shFF4C
		}
	};

	localparam act_t [0:NumHidden-1] HiddenBias = '{
		16'sh0040, 16'shFFC0, 16'sh0080, 16'sh0010
	};

	// Trained output layer, one row per class.
	localparam act_t [0:NumClasses-1][0:NumHidden-1] OutWeights = '{
		'{16'sh0190, 16'shFE70, 16'sh00C8, 16'shFF38},
		'{16'shFF10, 16'sh01E0, 16'shFF9C, 16'sh0120},
		'{16'sh0064, 16'shFF60, 16'sh0170, 16'sh00A0}
	};

	localparam act_t [0:NumClasses-1] OutBias = '{
		16'sh0020, 16'shFFF0, 16'sh0000
	};

	// One input sample.
	typedef struct packed {
		act_t [NumFeatures-1:0] feature;
	} featureVec_t;

	// Winning class and its score.
	typedef struct packed {
		logic [ClassIdxBits-1:0] classIdx;
		act_t score;
	} classResult_t;

endpackage

// ==== hw/neuronNode.sv ====
`timescale 1ns/100ps

module neuronNode #(
	parameter int NumInputs = 15,
	parameter fixedPointPkg::act_t [0:NumInputs-1] Weights = '0,
	parameter fixedPointPkg::act_t Bias = '0
) (
	input logic clk,
	input logic reset,
	input fixedPointPkg::act_t [NumInputs-1:0] inAct,
	output fixedPointPkg::act_t outAct
);

	import fixedPointPkg::*;

	act_t [NumInputs-1:0] inReg;
	prod_t product;
	acc_t macSum;
	acc_t sumReg;
	act_t satSum;

	// Stage 1. Capture the inputs.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
		end
		else
		begin
			inReg <= inAct;
		end
	end

	// Each product is rescaled to Q8.8 before it enters the sum.
	always_comb
	begin
		macSum = acc_t'(Bias);
		product = '0;
		for (int i = 0; i < NumInputs; i++)
		begin
			product = $signed(inReg[i]) * $signed(Weights[i]);
			macSum = macSum + acc_t'(product >>> FracBits);
		end
	end

	// Stage 2. Register the sum.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= macSum;
		end
	end

	// Clamp to the activation range.
	always_comb
	begin
		if (sumReg > acc_t'(ActMax))
			satSum = ActMax;
		else if (sumReg < acc_t'(ActMin))
			satSum = ActMin;
		else
			satSum = act_t'(sumReg);
	end

	// Stage 3. ReLU.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outAct <= '0;
		end
		else
		begin
			outAct <= (satSum < 0) ? act_t'(0) : satSum;
		end
	end

	outActNonNegative: assert property (@(posedge clk) disable iff (reset) outAct >= 0);

endmodule

// ==== hw/denseLayer.sv ====
`timescale 1ns/100ps

module denseLayer #(
	parameter int NumInputs = 15,
	parameter int NumNodes = 4,
	parameter fixedPointPkg::act_t [0:NumNodes-1][0:NumInputs-1] Weights = '0,
	parameter fixedPointPkg::act_t [0:NumNodes-1] Biases = '0
) (
	input logic clk,
	input logic reset,
	input fixedPointPkg::act_t [NumInputs-1:0] inAct,
	input logic inValid,
	output fixedPointPkg::act_t [NumNodes-1:0] outAct,
	output logic outValid
);

	// Matches the register stages inside neuronNode.
	localparam int Latency = 3;

	logic [Latency-1:0] validPipe;

	for (genvar n = 0; n < NumNodes; n++)
	begin : gNode
		neuronNode #(
			.NumInputs(NumInputs),
			.Weights(Weights[n]),
			.Bias(Biases[n])
		) uNode (
			.clk(clk),
			.reset(reset),
			.inAct(inAct),
			.outAct(outAct[n])
		);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[Latency-2:0], inValid};
		end
	end

	assign outValid = validPipe[Latency-1];

	// Valid lines up with neuron data once reset has been low long enough.
	validLatency: assert property (@(posedge clk) disable iff (reset)
		!$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3)
		|-> outValid == $past(inValid, Latency));

endmodule

// ==== hw/argMaxSelect.sv ====
`timescale 1ns/100ps

module argMaxSelect #(
	parameter int NumClasses = 3
) (
	input logic clk,
	input logic reset,
	input fixedPointPkg::act_t [NumClasses-1:0] score,
	input logic scoreValid,
	output mlpNetPkg::classResult_t result,
	output logic resultValid
);

	import fixedPointPkg::*;
	import mlpNetPkg::*;

	logic [ClassIdxBits-1:0] bestIdx;
	act_t bestScore;

	// Strict compare, so the lowest index keeps a tie.
	always_comb
	begin
		bestIdx = '0;
		bestScore = score[0];
		for (int i = 1; i < NumClasses; i++)
		begin
			if ($signed(score[i]) > $signed(bestScore))
			begin
				bestIdx = ClassIdxBits'(i);
				bestScore = score[i];
			end
		end
	end

	// Hold the last winner between strobes.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= scoreValid;
			if (scoreValid)
			begin
				result.classIdx <= bestIdx;
				result.score <= bestScore;
			end
		end
	end

	classIdxInRange: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> result.classIdx < NumClasses);

endmodule

// ==== hw/mlpTop.sv ====
`timescale 1ns/100ps

module mlpTop (
	input logic clk,
	input logic reset,
	input mlpNetPkg::featureVec_t sample,
	input logic sampleValid,
	output mlpNetPkg::classResult_t result,
	output logic resultValid
);

	import fixedPointPkg::*;
	import mlpNetPkg::*;

	act_t [NumHidden-1:0] hiddenAct;
	logic hiddenValid;
	act_t [NumClasses-1:0] classScore;
	logic scoreValid;

	// Features to hidden activations, 3 cycles.
	denseLayer #(
		.NumInputs(NumFeatures),
		.NumNodes(NumHidden),
		.Weights(HiddenWeights),
		.Biases(HiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inAct(sample.feature),
		.inValid(sampleValid),
		.outAct(hiddenAct),
		.outValid(hiddenValid)
	);

	// Hidden activations to class scores, 3 cycles.
	denseLayer #(
		.NumInputs(NumHidden),
		.NumNodes(NumClasses),
		.Weights(OutWeights),
		.Biases(OutBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inAct(hiddenAct),
		.inValid(hiddenValid),
		.outAct(classScore),
		.outValid(scoreValid)
	);

	// Winner select, 1 cycle.
	argMaxSelect #(
		.NumClasses(NumClasses)
	) uArgMax (
		.clk(clk),
		.reset(reset),
		.score(classScore),
		.scoreValid(scoreValid),
		.result(result),
		.resultValid(resultValid)
	);

endmodule

// ==== tb/mlpChecker.sv ====
`timescale 1ns/100ps

module mlpChecker (
	input logic clk,
	input logic reset,
	input mlpNetPkg::featureVec_t sample,
	input logic sampleValid,
	input mlpNetPkg::classResult_t result,
	input logic resultValid,
	output int resultCount,
	output int valueErrors,
	output int protocolErrors,
	output int pendingCount
);

	import fixedPointPkg::*;
	import mlpNetPkg::*;

	// Sample to result, in cycles.
	localparam int Latency = 7;

	classResult_t expQ[$];
	longint dueQ[$];
	longint cycleNo = 0;

	// Q8.8 product, rescaled with floor rounding.
	function automatic longint scaledProduct(act_t a, act_t w);
		return (longint'(a) * longint'(w)) >>> FracBits;
	endfunction

	// Clamp to the top of the range; negatives become zero.
	function automatic act_t satRelu(longint sum);
		if (sum > longint'(ActMax))
			return ActMax;
		if (sum < 0)
			return '0;
		return act_t'(sum);
	endfunction

	function automatic classResult_t refModel(featureVec_t s);
		act_t hidden [NumHidden];
		act_t scores [NumClasses];
		act_t best;
		longint sum;
		classResult_t r;
		for (int n = 0; n < NumHidden; n++)
		begin
			sum = longint'(HiddenBias[n]);
			for (int i = 0; i < NumFeatures; i++)
			begin
				sum += scaledProduct(s.feature[i], HiddenWeights[n][i]);
			end
			hidden[n] = satRelu(sum);
		end
		for (int c = 0; c < NumClasses; c++)
		begin
			sum = longint'(OutBias[c]);
			for (int n = 0; n < NumHidden; n++)
			begin
				sum += scaledProduct(hidden[n], OutWeights[c][n]);
			end
			scores[c] = satRelu(sum);
		end
		// First of equal scores wins.
		r.classIdx = '0;
		best = scores[0];
		for (int c = 1; c < NumClasses; c++)
		begin
			if (scores[c] > best)
			begin
				r.classIdx = ClassIdxBits'(c);
				best = scores[c];
			end
		end
		r.score = best;
		return r;
	endfunction

	always @(posedge clk)
	begin
		classResult_t expected;
		longint due;
		cycleNo++;
		if (reset)
		begin
			if (resultValid)
			begin
				$display("resultValid was high during reset at cycle %0d", cycleNo);
				protocolErrors++;
			end
		end
		else
		begin
			if (resultValid)
			begin
				resultCount++;
				if (expQ.size() == 0)
				begin
					$display("A result arrived at cycle %0d with no sample pending", cycleNo);
					protocolErrors++;
				end
				else
				begin
					expected = expQ.pop_front();
					due = dueQ.pop_front();
					if (due != cycleNo)
					begin
						$display("A result arrived at cycle %0d but was due at cycle %0d",
							cycleNo, due);
						protocolErrors++;
					end
					if (result.classIdx !== expected.classIdx)
					begin
						$display("ERROR result.classIdx: got 0x%h, expected 0x%h",
							result.classIdx, expected.classIdx);
						valueErrors++;
					end
					if (result.score !== expected.score)
					begin
						$display("ERROR result.score: got 0x%h, expected 0x%h",
							result.score, expected.score);
						valueErrors++;
					end
				end
			end
			else if (dueQ.size() != 0 && dueQ[0] <= cycleNo)
			begin
				$display("No result arrived at cycle %0d for a pending sample", cycleNo);
				void'(expQ.pop_front());
				void'(dueQ.pop_front());
				protocolErrors++;
			end
			if (sampleValid)
			begin
				expQ.push_back(refModel(sample));
				dueQ.push_back(cycleNo + Latency);
			end
		end
		pendingCount = expQ.size();
	end

endmodule

// ==== tb/mlpTb.sv ====
`timescale 1ns/100ps

module mlpTb;

	import fixedPointPkg::*;
	import mlpNetPkg::*;

	localparam int ClkPeriod = 20;
	localparam int ResetCycles = 10;
	localparam int RandSeed = 97841;
	localparam int PipeLatency = 7;
	localparam int LeadCycles = 5;
	localparam int NumDirected = 6;
	localparam int DirectedGap = 10;
	localparam int NumRandom = 400;
	// At most one idle cycle after each random sample.
	localparam int RandomCycles = 2 * NumRandom;
	localparam int NumSaturation = 6;
	localparam int TailCycles = 3;
	localparam int PhaseCycles = LeadCycles + NumDirected + DirectedGap + 1 + RandomCycles
		+ NumSaturation + 1 + PipeLatency + TailCycles;
	localparam int TimeoutNs = (ResetCycles + PhaseCycles + PipeLatency) * 2 * ClkPeriod;

	logic clk = 1'b0;
	logic reset;
	featureVec_t sample;
	logic sampleValid;
	classResult_t result;
	logic resultValid;

	int resultCount;
	int valueErrors;
	int protocolErrors;
	int pendingCount;
	int samplesSent = 0;
	int countErrors = 0;

	always #(ClkPeriod / 2) clk = ~clk;

	mlpTop i_dut (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.result(result),
		.resultValid(resultValid)
	);

	mlpChecker uChecker (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.result(result),
		.resultValid(resultValid),
		.resultCount(resultCount),
		.valueErrors(valueErrors),
		.protocolErrors(protocolErrors),
		.pendingCount(pendingCount)
	);

	// Features within +-4.0.
	function automatic featureVec_t randomSample();
		featureVec_t s;
		for (int i = 0; i < NumFeatures; i++)
		begin
			s.feature[i] = act_t'(int'($urandom_range(0, 2047)) - 1024);
		end
		return s;
	endfunction

	function automatic featureVec_t directedSample(int k);
		featureVec_t s;
		s = '0;
		for (int i = 0; i < NumFeatures; i++)
		begin
			case (k)
				1: s.feature[i] = 16'sh0100;
				2: s.feature[i] = 16'shFF00;
				3: s.feature[i] = (i % 2 == 0) ? 16'sh0080 : 16'shFF80;
				4: s.feature[i] = (i == 7) ? 16'sh0200 : 16'sh0000;
				5: s.feature[i] = act_t'((i - 7) * 32);
				default: s.feature[i] = '0;
			endcase
		end
		return s;
	endfunction

	// Extremes, then each hidden row driven hard along its weight signs.
	function automatic featureVec_t saturationSample(int k);
		featureVec_t s;
		for (int i = 0; i < NumFeatures; i++)
		begin
			case (k)
				0: s.feature[i] = ActMax;
				1: s.feature[i] = ActMin;
				default: s.feature[i] = (HiddenWeights[k - 2][i] < 0) ? ActMin : ActMax;
			endcase
		end
		return s;
	endfunction

	task automatic driveSample(input featureVec_t s);
		@(negedge clk);
		sample = s;
		sampleValid = 1'b1;
		samplesSent++;
	endtask

	// Noise on the data lines while valid is low.
	task automatic idleCycle();
		@(negedge clk);
		sample = randomSample();
		sampleValid = 1'b0;
	endtask

	initial
	begin
		#(TimeoutNs);
		$display("Timeout after %0d ns: results did not arrive", TimeoutNs);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		sample = '0;
		sampleValid = 1'b0;
		void'($urandom(RandSeed));
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		repeat (LeadCycles) idleCycle();

		// Zero sample alone, so the bias-only result stands apart.
		driveSample(directedSample(0));
		repeat (DirectedGap) idleCycle();
		for (int k = 1; k < NumDirected; k++)
		begin
			driveSample(directedSample(k));
		end
		idleCycle();

		// About 70 percent valid.
		for (int k = 0; k < NumRandom; k++)
		begin
			driveSample(randomSample());
			if ($urandom_range(0, 6) >= 4)
				idleCycle();
		end

		for (int k = 0; k < NumSaturation; k++)
		begin
			driveSample(saturationSample(k));
		end
		idleCycle();

		while (pendingCount != 0)
			idleCycle();
		repeat (TailCycles) idleCycle();

		if (resultCount != samplesSent)
		begin
			$display("Sent %0d samples but received %0d results", samplesSent, resultCount);
			countErrors = 1;
		end
		$display("Results: %0d, value errors: %0d, protocol errors: %0d, count errors: %0d",
			resultCount, valueErrors, protocolErrors, countErrors);
		if (valueErrors + protocolErrors + countErrors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== mlpTop.f ====
hw/fixedPointPkg.sv
hw/mlpNetPkg.sv
hw/neuronNode.sv
hw/denseLayer.sv
hw/argMaxSelect.sv
hw/mlpTop.sv
tb/mlpChecker.sv
tb/mlpTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
TOP       := mlpTb
FILELIST  := mlpTop.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
